// File: hdl/fft_pkg.sv
// Sizes, FSM state codes, the complex sample word and the twiddle table
// of the 16-point decimation-in-time FFT.
package fft_pkg;

   // Transform length and address width.
   localparam int FFT_N    = 16;
   localparam int FFT_LOG2 = 4;
   // Bits per real or imaginary part.
   localparam int X_WDTH   = 8;
   // Fraction bits of the twiddle values, so 1.0 is 64.
   localparam int TF_FRAC  = 6;

   // Stage controller states.
   localparam logic [1:0] ST_INIT = 2'd0;
   localparam logic [1:0] ST_IDLE = 2'd1;
   localparam logic [1:0] ST_CALC = 2'd2;
   localparam logic [1:0] ST_SEND = 2'd3;

   // One complex sample.
   // Real part in the low byte, imaginary part in the high byte.
   typedef union packed {
      logic [2*X_WDTH-1:0] raw;
      struct packed {
         logic signed [X_WDTH-1:0] im;
         logic signed [X_WDTH-1:0] re;
      } parts;
   } cplx_t;

   // Entry n holds cos and -sin of 2*pi*n/16, times 64, rounded.
   localparam logic signed [X_WDTH-1:0] TW_RE [FFT_N/2] = '{
      8'sd64, 8'sd59, 8'sd45, 8'sd24, 8'sd0, -8'sd24, -8'sd45, -8'sd59};
   localparam logic signed [X_WDTH-1:0] TW_IM [FFT_N/2] = '{
      8'sd0, -8'sd24, -8'sd45, -8'sd59, -8'sd64, -8'sd59, -8'sd45, -8'sd24};

endpackage

// File: hdl/fft_input_buffer.sv
// Ping-pong input banks with write address, full flags
// and the sticky overflow flag.
`timescale 1ns/1ps

module fft_input_buffer import fft_pkg::*; (
   input  logic                clk,
   input  logic                rst_n,
   input  cplx_t               in_x,
   input  logic                in_nd,
   input  logic                frame_release,
   input  logic [FFT_LOG2-1:0] rd_addr0,
   input  logic [FFT_LOG2-1:0] rd_addr1,
   output cplx_t               in_rd0,
   output cplx_t               in_rd1,
   output logic                frame_ready,
   output logic                overflow
);

   // Two banks of one frame each.
   cplx_t               mem [2][FFT_N];
   logic [FFT_LOG2-1:0] wr_addr;
   // Bank being filled and bank being read by the controller.
   logic                wr_bank;
   logic                rd_bank;
   // One full flag per bank.
   logic [1:0]          full;

   always_ff @(posedge clk) begin
      if (in_nd)
      begin
         mem[wr_bank][wr_addr] <= in_x;
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n)
      begin
         wr_addr  <= '0;
         wr_bank  <= 1'b0;
         rd_bank  <= 1'b0;
         full     <= '0;
         overflow <= 1'b0;
      end
      else
      begin
         if (in_nd)
         begin
            // A sample into a bank not yet consumed is lost data.
            if (full[wr_bank])
            begin
               overflow <= 1'b1;
            end
            wr_addr <= wr_addr + FFT_LOG2'(1);
            // Last word closes the bank and moves to the other one.
            if (&wr_addr)
            begin
               full[wr_bank] <= 1'b1;
               wr_bank       <= ~wr_bank;
            end
         end
         // Controller has finished the first stage on this bank.
         if (frame_release)
         begin
            full[rd_bank] <= 1'b0;
            rd_bank       <= ~rd_bank;
         end
      end
   end

   assign frame_ready = full[rd_bank];
   assign in_rd0      = mem[rd_bank][rd_addr0];
   assign in_rd1      = mem[rd_bank][rd_addr1];

   // Release only ever frees a bank the controller found full.
   a_release_when_ready: assert property (@(posedge clk) disable iff (!rst_n)
      frame_release |-> frame_ready);

endmodule

// File: hdl/fft_stage_control.sv
// Stage controller FSM.
// Stage and position counters, butterfly and twiddle address generation.
`timescale 1ns/1ps

module fft_stage_control import fft_pkg::*; (
   input  logic                clk,
   input  logic                rst_n,
   input  logic                frame_ready,
   input  logic                operands_ready,
   output logic [2:0]          tf_addr,
   output logic                tf_addr_nd,
   output logic                x_nd,
   output logic                stage_advance,
   output logic                frame_release,
   output logic                first_stage,
   output logic                last_stage,
   output logic                last_pair,
   output logic                rd_bank,
   output logic [FFT_LOG2-1:0] rd_addr0,
   output logic [FFT_LOG2-1:0] rd_addr1,
   output logic [FFT_LOG2-1:0] out0_addr,
   output logic [FFT_LOG2-1:0] out1_addr
);

   logic [1:0]          state;
   // Number of interleaved series in the stage being written.
   logic [FFT_LOG2-1:0] s_cnt;
   // Ones on the out0_addr bits that pick the series j.
   logic [FFT_LOG2-1:0] series_mask;
   // The k*S part of out0_addr.
   logic [FFT_LOG2-1:0] k_part;
   logic                last_pos;

   // out0 = k*S + j, out1 = out0 + N/2.
   assign out1_addr   = {1'b1, out0_addr[FFT_LOG2-2:0]};
   assign k_part      = out0_addr & ~series_mask;
   // in0 = 2*k*S + j, in1 = in0 + S.
   assign rd_addr0    = (out0_addr & series_mask) | (k_part << 1);
   assign rd_addr1    = rd_addr0 + s_cnt;
   assign tf_addr     = k_part[2:0];
   // S is N/2 in the first stage and 1 in the last.
   assign first_stage = s_cnt[FFT_LOG2-1];
   assign last_stage  = s_cnt[0];
   assign last_pos    = &out1_addr;
   assign last_pair   = last_stage & last_pos;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n)
      begin
         state         <= ST_INIT;
         s_cnt         <= '0;
         series_mask   <= '0;
         out0_addr     <= '0;
         rd_bank       <= 1'b0;
         x_nd          <= 1'b0;
         tf_addr_nd    <= 1'b0;
         stage_advance <= 1'b0;
         frame_release <= 1'b0;
      end
      else
      begin
         // Strobes last one cycle unless set below.
         x_nd          <= 1'b0;
         tf_addr_nd    <= 1'b0;
         stage_advance <= 1'b0;
         frame_release <= 1'b0;
         case (state)
            ST_INIT:
            begin
               // Prepare the first stage and fetch the first twiddle.
               out0_addr   <= '0;
               series_mask <= {1'b0, {(FFT_LOG2-1){1'b1}}};
               s_cnt       <= {1'b1, {(FFT_LOG2-1){1'b0}}};
               tf_addr_nd  <= 1'b1;
               state       <= ST_IDLE;
            end
            ST_IDLE:
            begin
               // Wait for a full input bank.
               if (frame_ready)
               begin
                  x_nd  <= 1'b1;
                  state <= ST_CALC;
               end
            end
            ST_CALC:
            begin
               tf_addr_nd <= 1'b1;
               state      <= ST_SEND;
               if (last_pos)
               begin
                  // Next stage has half as many series.
                  series_mask   <= series_mask >> 1;
                  s_cnt         <= s_cnt >> 1;
                  out0_addr     <= '0;
                  rd_bank       <= ~rd_bank;
                  stage_advance <= 1'b1;
                  // Input bank is no longer needed after the first stage.
                  frame_release <= first_stage;
               end
               else
               begin
                  out0_addr <= out0_addr + FFT_LOG2'(1);
               end
            end
            ST_SEND:
            begin
               // Hold until both operands have been written.
               if (operands_ready)
               begin
                  x_nd  <= 1'b1;
                  state <= last_pair ? ST_INIT : ST_CALC;
               end
            end
         endcase
      end
   end

   // Series count and mask shift together, S stays a single bit.
   a_series_consistent: assert property (@(posedge clk) disable iff (!rst_n)
      (state != ST_INIT) |-> ($onehot(s_cnt) && series_mask == s_cnt - FFT_LOG2'(1)));

endmodule

// File: hdl/twiddle_rom.sv
// Registered twiddle factor lookup.
`timescale 1ns/1ps

module twiddle_rom import fft_pkg::*; (
   input  logic       clk,
   input  logic       rst_n,
   input  logic [2:0] tf_addr,
   input  logic       tf_addr_nd,
   output cplx_t      tf
);

   // New factor loads on each request and holds until the next.
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n)
      begin
         tf <= '0;
      end
      else if (tf_addr_nd)
      begin
         tf.parts.re <= TW_RE[tf_addr];
         tf.parts.im <= TW_IM[tf_addr];
      end
   end

endmodule

// File: hdl/butterfly.sv
// Two-stage pipelined radix-2 butterfly.
// Carries result addresses and stage tags alongside the data.
`timescale 1ns/1ps

module butterfly import fft_pkg::*; (
   input  logic                clk,
   input  logic                rst_n,
   input  logic                x_nd,
   input  logic                last_stage,
   input  logic                last_pair,
   input  logic                rd_bank,
   input  cplx_t               xa,
   input  cplx_t               xb,
   input  cplx_t               w,
   input  logic [FFT_LOG2-1:0] out0_addr,
   input  logic [FFT_LOG2-1:0] out1_addr,
   output cplx_t               y,
   output logic [FFT_LOG2-1:0] y_addr,
   output logic                y_nd,
   output logic                y_last_stage,
   output logic                y_last_pair,
   output logic                y_rd_bank
);

   // Full-width products and the scaled product p = w * xb.
   logic signed [2*X_WDTH:0]         prod_re;
   logic signed [2*X_WDTH:0]         prod_im;
   logic signed [2*X_WDTH-TF_FRAC:0] p_re;
   logic signed [2*X_WDTH-TF_FRAC:0] p_im;
   // xa + p and xa - p before halving.
   logic signed [2*X_WDTH-TF_FRAC+1:0] sum_re;
   logic signed [2*X_WDTH-TF_FRAC+1:0] sum_im;
   logic signed [2*X_WDTH-TF_FRAC+1:0] dif_re;
   logic signed [2*X_WDTH-TF_FRAC+1:0] dif_im;
   cplx_t               a_q;
   cplx_t               za;
   cplx_t               zb;
   cplx_t               zb_hold;
   logic [FFT_LOG2-1:0] addr0_q;
   logic [FFT_LOG2-1:0] addr1_q;
   logic [FFT_LOG2-1:0] addr1_hold;
   logic                last_stage_q;
   logic                last_pair_q;
   logic                rd_bank_q;
   // Valid bits of pipeline stage 1 and of the zb slot.
   logic                v1;
   logic                v2;

   assign prod_re = w.parts.re * xb.parts.re - w.parts.im * xb.parts.im;
   assign prod_im = w.parts.re * xb.parts.im + w.parts.im * xb.parts.re;

   // Stage 1: scaled product, xa and tags.
   always_ff @(posedge clk) begin
      if (x_nd)
      begin
         p_re         <= prod_re[2*X_WDTH:TF_FRAC];
         p_im         <= prod_im[2*X_WDTH:TF_FRAC];
         a_q          <= xa;
         addr0_q      <= out0_addr;
         addr1_q      <= out1_addr;
         last_stage_q <= last_stage;
         last_pair_q  <= last_pair;
         rd_bank_q    <= rd_bank;
      end
   end

   // Stage 2 arithmetic, halved and truncated to the sample width.
   assign sum_re = a_q.parts.re + p_re;
   assign sum_im = a_q.parts.im + p_im;
   assign dif_re = a_q.parts.re - p_re;
   assign dif_im = a_q.parts.im - p_im;

   always_comb begin
      za.parts.re = sum_re[X_WDTH:1];
      za.parts.im = sum_im[X_WDTH:1];
      zb.parts.re = dif_re[X_WDTH:1];
      zb.parts.im = dif_im[X_WDTH:1];
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n)
      begin
         v1   <= 1'b0;
         v2   <= 1'b0;
         y_nd <= 1'b0;
      end
      else
      begin
         v1   <= x_nd;
         v2   <= v1;
         y_nd <= v1 | v2;
      end
   end

   // za goes out first, zb waits one cycle in the hold register.
   always_ff @(posedge clk) begin
      if (v1)
      begin
         y            <= za;
         y_addr       <= addr0_q;
         zb_hold      <= zb;
         addr1_hold   <= addr1_q;
         y_last_stage <= last_stage_q;
         y_last_pair  <= last_pair_q;
         y_rd_bank    <= rd_bank_q;
      end
      else if (v2)
      begin
         y      <= zb_hold;
         y_addr <= addr1_hold;
      end
   end

   // The zb slot assumes a gap of at least one cycle between pairs.
   a_no_back_to_back: assert property (@(posedge clk) disable iff (!rst_n)
      x_nd |=> !x_nd);

endmodule

// File: hdl/fft_work_memory.sv
// Working banks X and Y with per-word updated flags.
// Operand selection and butterfly result routing.
`timescale 1ns/1ps

module fft_work_memory import fft_pkg::*; (
   input  logic                clk,
   input  logic                rst_n,
   input  logic                first_stage,
   input  logic                rd_bank,
   input  logic                stage_advance,
   input  logic [FFT_LOG2-1:0] rd_addr0,
   input  logic [FFT_LOG2-1:0] rd_addr1,
   input  cplx_t               in_rd0,
   input  cplx_t               in_rd1,
   input  cplx_t               y,
   input  logic [FFT_LOG2-1:0] y_addr,
   input  logic                y_nd,
   input  logic                y_last_stage,
   input  logic                y_last_pair,
   input  logic                y_rd_bank,
   output cplx_t               xa,
   output cplx_t               xb,
   output logic                operands_ready,
   output logic                out_we,
   output logic                frame_done,
   output logic [FFT_LOG2-1:0] out_addr,
   output cplx_t               out_data
);

   cplx_t            mem [2][FFT_N];
   // Set when a word has been written in the current pass.
   logic [FFT_N-1:0] updated [2];
   logic             bank_we;
   logic             wr_sel;
   // High while the next result is zb.
   logic             zb_phase;

   // First stage reads the input buffer directly.
   assign xa = first_stage ? in_rd0 : mem[rd_bank][rd_addr0];
   assign xb = first_stage ? in_rd1 : mem[rd_bank][rd_addr1];
   assign operands_ready = first_stage |
                           (updated[rd_bank][rd_addr0] & updated[rd_bank][rd_addr1]);

   // Results of the last stage bypass the banks.
   assign bank_we  = y_nd & ~y_last_stage;
   assign wr_sel   = ~y_rd_bank;
   assign out_we   = y_nd & y_last_stage;
   assign out_addr = y_addr;
   assign out_data = y;

   always_ff @(posedge clk) begin
      if (bank_we)
      begin
         mem[wr_sel][y_addr] <= y;
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n)
      begin
         updated[0] <= '0;
         updated[1] <= '0;
         zb_phase   <= 1'b0;
         frame_done <= 1'b0;
      end
      else
      begin
         // Results come in za, zb pairs.
         zb_phase   <= zb_phase ^ y_nd;
         frame_done <= y_nd & zb_phase & y_last_pair;
         // The bank the new stage writes starts out stale.
         if (stage_advance)
         begin
            updated[~rd_bank] <= '0;
         end
         if (bank_we)
         begin
            updated[wr_sel][y_addr] <= 1'b1;
         end
      end
   end

endmodule

// File: hdl/fft_output_buffer.sv
// Output frame memory and the emit counter.
`timescale 1ns/1ps

module fft_output_buffer import fft_pkg::*; (
   input  logic                clk,
   input  logic                rst_n,
   input  logic                out_we,
   input  logic                frame_done,
   input  logic [FFT_LOG2-1:0] out_addr,
   input  cplx_t               out_data,
   output cplx_t               out_x,
   output logic                out_nd
);

   cplx_t               mem [FFT_N];
   logic                emitting;
   logic [FFT_LOG2-1:0] rd_cnt;

   // Results land in natural order by address.
   always_ff @(posedge clk) begin
      if (out_we)
      begin
         mem[out_addr] <= out_data;
      end
      if (emitting)
      begin
         out_x <= mem[rd_cnt];
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n)
      begin
         emitting <= 1'b0;
         rd_cnt   <= '0;
         out_nd   <= 1'b0;
      end
      else
      begin
         out_nd <= emitting;
         if (frame_done)
         begin
            emitting <= 1'b1;
         end
         // Sixteen words back to back, then stop.
         if (emitting)
         begin
            rd_cnt <= rd_cnt + FFT_LOG2'(1);
            if (&rd_cnt)
            begin
               emitting <= 1'b0;
            end
         end
      end
   end

   // A new frame must not overwrite one still being emitted.
   a_done_while_idle: assert property (@(posedge clk) disable iff (!rst_n)
      frame_done |-> !emitting);

endmodule

// File: hdl/fft_dit_top.sv
// Top level of the 16-point DIT FFT.
// Input buffer, controller, twiddle ROM, butterfly, work and output memories.
`timescale 1ns/1ps

module fft_dit_top import fft_pkg::*; (
   input  logic  clk,
   input  logic  rst_n,
   input  cplx_t in_x,
   input  logic  in_nd,
   output cplx_t out_x,
   output logic  out_nd,
   output logic  overflow
);

   // Input buffer and controller.
   logic                frame_ready;
   logic                frame_release;
   logic [FFT_LOG2-1:0] rd_addr0;
   logic [FFT_LOG2-1:0] rd_addr1;
   cplx_t               in_rd0;
   cplx_t               in_rd1;
   logic                operands_ready;
   // Twiddle request and factor.
   logic [2:0]          tf_addr;
   logic                tf_addr_nd;
   cplx_t               tf;
   // Butterfly issue side.
   logic                x_nd;
   logic                stage_advance;
   logic                first_stage;
   logic                last_stage;
   logic                last_pair;
   logic                rd_bank;
   logic [FFT_LOG2-1:0] out0_addr;
   logic [FFT_LOG2-1:0] out1_addr;
   cplx_t               xa;
   cplx_t               xb;
   // Butterfly results.
   cplx_t               y;
   logic [FFT_LOG2-1:0] y_addr;
   logic                y_nd;
   logic                y_last_stage;
   logic                y_last_pair;
   logic                y_rd_bank;
   // Toward the output buffer.
   logic                out_we;
   logic                frame_done;
   logic [FFT_LOG2-1:0] out_addr;
   cplx_t               out_data;

   fft_input_buffer u_input (
      .clk(clk), .rst_n(rst_n), .in_x(in_x), .in_nd(in_nd),
      .frame_release(frame_release), .rd_addr0(rd_addr0), .rd_addr1(rd_addr1),
      .in_rd0(in_rd0), .in_rd1(in_rd1), .frame_ready(frame_ready), .overflow(overflow)
   );

   fft_stage_control u_ctrl (
      .clk(clk), .rst_n(rst_n), .frame_ready(frame_ready),
      .operands_ready(operands_ready), .tf_addr(tf_addr), .tf_addr_nd(tf_addr_nd),
      .x_nd(x_nd), .stage_advance(stage_advance), .frame_release(frame_release),
      .first_stage(first_stage), .last_stage(last_stage), .last_pair(last_pair),
      .rd_bank(rd_bank), .rd_addr0(rd_addr0), .rd_addr1(rd_addr1),
      .out0_addr(out0_addr), .out1_addr(out1_addr)
   );

   twiddle_rom u_twiddle (
      .clk(clk), .rst_n(rst_n), .tf_addr(tf_addr), .tf_addr_nd(tf_addr_nd), .tf(tf)
   );

   butterfly u_bf (
      .clk(clk), .rst_n(rst_n), .x_nd(x_nd), .last_stage(last_stage),
      .last_pair(last_pair), .rd_bank(rd_bank), .xa(xa), .xb(xb), .w(tf),
      .out0_addr(out0_addr), .out1_addr(out1_addr), .y(y), .y_addr(y_addr),
      .y_nd(y_nd), .y_last_stage(y_last_stage), .y_last_pair(y_last_pair),
      .y_rd_bank(y_rd_bank)
   );

   fft_work_memory u_work (
      .clk(clk), .rst_n(rst_n), .first_stage(first_stage), .rd_bank(rd_bank),
      .stage_advance(stage_advance), .rd_addr0(rd_addr0), .rd_addr1(rd_addr1),
      .in_rd0(in_rd0), .in_rd1(in_rd1), .y(y), .y_addr(y_addr), .y_nd(y_nd),
      .y_last_stage(y_last_stage), .y_last_pair(y_last_pair), .y_rd_bank(y_rd_bank),
      .xa(xa), .xb(xb), .operands_ready(operands_ready), .out_we(out_we),
      .frame_done(frame_done), .out_addr(out_addr), .out_data(out_data)
   );

   fft_output_buffer u_output (
      .clk(clk), .rst_n(rst_n), .out_we(out_we), .frame_done(frame_done),
      .out_addr(out_addr), .out_data(out_data), .out_x(out_x), .out_nd(out_nd)
   );

endmodule

// File: sim/tb_clock.sv
// Testbench clock and power-on reset generator.
`timescale 1ns/1ps

module tb_clock (
   output logic clk,
   output logic por_n
);

   // 20 ns period.
   initial
   begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   // Reset held for 8 cycles, released just after an edge.
   initial
   begin
      por_n = 1'b0;
      repeat (8) @(posedge clk);
      #2;
      por_n = 1'b1;
   end

endmodule

// File: sim/fft_dit_tb.sv
// FFT testbench with random and directed frames and a reference model of the four stages.
// Also holds the output monitor, the compare task and the final report.
`timescale 1ns/1ps

module fft_dit_tb import fft_pkg::*; ();

   localparam int SEED         = 32'h22acd3a3;
   localparam int DRAIN_LIMIT  = 4000;
   localparam int RESET_LIMIT  = 50;
   localparam int QUIET_CYCLES = 400;

   logic        clk;
   logic        por_n;
   logic        sw_rst_n;
   logic        rst_n;
   cplx_t       in_x;
   logic        in_nd;
   cplx_t       out_x;
   logic        out_nd;
   logic        overflow;

   // Samples of the frame being sent.
   cplx_t       frame_buf [FFT_N];
   // Expected output words, oldest first.
   logic [15:0] exp_q [$];
   string       cur_test;
   bit          check_outputs;
   // Words seen so far in the current output burst.
   int          run_len;
   int          tests;
   int          checks;
   int          errors;
   int          test_err_base;

   // Power-on reset and resets issued by the tests.
   assign rst_n = por_n & sw_rst_n;

   tb_clock clk_gen (
      .clk(clk),
      .por_n(por_n)
   );

   fft_dit_top uut (
      .clk(clk), .rst_n(rst_n), .in_x(in_x), .in_nd(in_nd),
      .out_x(out_x), .out_nd(out_nd), .overflow(overflow)
   );

   task automatic check_value(input string name, input logic [15:0] expected,
                              input logic [15:0] actual);
      checks++;
      if (actual !== expected)
      begin
         errors++;
         $display("error %s %s: expected %h, actual %h", cur_test, name, expected, actual);
      end
   endtask

   task automatic report_problem(input string msg);
      errors++;
      $display("%s", msg);
   endtask

   // Expected frame from the four radix-2 stages.
   // out0 = k*S + j reads in0 = 2*k*S + j and in0 + S, twiddle index k*S.
   task automatic queue_expected();
      cplx_t cur [FFT_N];
      cplx_t nxt [FFT_N];
      int    s;
      int    j;
      int    k;
      int    in0;
      int    in1;
      int    a_re;
      int    a_im;
      int    b_re;
      int    b_im;
      int    w_re;
      int    w_im;
      int    p_re;
      int    p_im;
      cur = frame_buf;
      for (int stage = 0; stage < FFT_LOG2; stage++)
      begin
         s = FFT_N >> (stage + 1);
         for (int pos = 0; pos < FFT_N / 2; pos++)
         begin
            // Position splits into series j and butterfly k.
            j     = pos % s;
            k     = pos / s;
            in0   = 2 * k * s + j;
            in1   = in0 + s;
            a_re  = $signed(cur[in0].parts.re);
            a_im  = $signed(cur[in0].parts.im);
            b_re  = $signed(cur[in1].parts.re);
            b_im  = $signed(cur[in1].parts.im);
            w_re  = TW_RE[k * s];
            w_im  = TW_IM[k * s];
            // Product scaled back by the twiddle fraction, floor rounding.
            p_re  = (w_re * b_re - w_im * b_im) >>> TF_FRAC;
            p_im  = (w_re * b_im + w_im * b_re) >>> TF_FRAC;
            // Halved sum and difference, wrapped to the sample width.
            nxt[pos].parts.re             = X_WDTH'((a_re + p_re) >>> 1);
            nxt[pos].parts.im             = X_WDTH'((a_im + p_im) >>> 1);
            nxt[pos + FFT_N / 2].parts.re = X_WDTH'((a_re - p_re) >>> 1);
            nxt[pos + FFT_N / 2].parts.im = X_WDTH'((a_im - p_im) >>> 1);
         end
         cur = nxt;
      end
      for (int i = 0; i < FFT_N; i++)
      begin
         exp_q.push_back(cur[i].raw);
      end
   endtask

   // Every output word is compared with the oldest expected word.
   always @(negedge clk)
   begin
      if (!rst_n)
      begin
         run_len = 0;
      end
      else if (out_nd)
      begin
         if (check_outputs)
         begin
            if (exp_q.size() == 0)
            begin
               report_problem("output word appeared with no frame pending");
            end
            else
            begin
               check_value($sformatf("word %0d", run_len),
                           exp_q.pop_front(), out_x.raw);
            end
         end
         run_len = (run_len + 1) % FFT_N;
      end
      else if (run_len != 0)
      begin
         report_problem("output frame broke off before its sixteenth word");
         run_len = 0;
      end
   end

   task automatic make_random_frame();
      for (int i = 0; i < FFT_N; i++)
      begin
         // Parts in -32 to 31.
         frame_buf[i].parts.re = X_WDTH'(int'($urandom_range(63)) - 32);
         frame_buf[i].parts.im = X_WDTH'(int'($urandom_range(63)) - 32);
      end
   endtask

   task automatic make_constant_frame();
      for (int i = 0; i < FFT_N; i++)
      begin
         frame_buf[i].parts.re = X_WDTH'(25);
         frame_buf[i].parts.im = X_WDTH'(-17);
      end
   endtask

   task automatic make_impulse_frame();
      for (int i = 0; i < FFT_N; i++)
      begin
         frame_buf[i] = '0;
      end
      frame_buf[0].parts.re = X_WDTH'(31);
      frame_buf[0].parts.im = X_WDTH'(-20);
   endtask

   // One sample per cycle, in_nd left high after the last one.
   task automatic drive_samples(input int count);
      for (int i = 0; i < count; i++)
      begin
         @(posedge clk);
         #2;
         in_x  = frame_buf[i];
         in_nd = 1'b1;
      end
   endtask

   task automatic end_input();
      @(posedge clk);
      #2;
      in_nd = 1'b0;
   endtask

   task automatic send_frame(input bit expect_out);
      drive_samples(FFT_N);
      end_input();
      if (expect_out)
      begin
         queue_expected();
      end
   endtask

   task automatic idle_cycles(input int n);
      repeat (n) @(posedge clk);
   endtask

   // Pending frames are dropped along with the DUT state.
   task automatic apply_reset();
      @(posedge clk);
      #2;
      sw_rst_n = 1'b0;
      in_nd    = 1'b0;
      exp_q.delete();
      run_len  = 0;
      repeat (8) @(posedge clk);
      #2;
      sw_rst_n = 1'b1;
   endtask

   task automatic wait_output_drain();
      int cycles;
      cycles = 0;
      while ((exp_q.size() != 0 || run_len != 0) && cycles < DRAIN_LIMIT)
      begin
         @(posedge clk);
         cycles++;
      end
      if (exp_q.size() != 0 || run_len != 0)
      begin
         report_problem($sformatf("timeout in %s: %0d expected output words never came",
                                  cur_test, exp_q.size()));
         exp_q.delete();
      end
   endtask

   task automatic start_test(input string name);
      cur_test      = name;
      test_err_base = errors;
      tests++;
   endtask

   task automatic end_test();
      if (errors == test_err_base)
      begin
         $display("test %s: ok", cur_test);
      end
      else
      begin
         $display("test %s: %0d errors", cur_test, errors - test_err_base);
      end
   endtask

   initial
   begin
      int cycles;
      int stale;
      bit held;
      void'($urandom(SEED));
      in_x          = '0;
      in_nd         = 1'b0;
      sw_rst_n      = 1'b1;
      check_outputs = 1'b1;
      run_len       = 0;
      tests         = 0;
      checks        = 0;
      errors        = 0;
      cur_test      = "power_on";

      cycles = 0;
      while (por_n !== 1'b1 && cycles < RESET_LIMIT)
      begin
         @(posedge clk);
         cycles++;
      end
      if (por_n !== 1'b1)
      begin
         report_problem("power-on reset was never released");
      end
      @(negedge clk);

      start_test("reset_single_frame");
      check_value("out_nd_after_reset", 16'd0, {15'd0, out_nd});
      check_value("overflow_after_reset", 16'd0, {15'd0, overflow});
      make_random_frame();
      send_frame(1'b1);
      wait_output_drain();
      end_test();

      start_test("constant_and_impulse");
      make_constant_frame();
      send_frame(1'b1);
      wait_output_drain();
      make_impulse_frame();
      send_frame(1'b1);
      wait_output_drain();
      end_test();

      // Gaps leave the controller time to finish each frame.
      start_test("random_frames_with_gaps");
      for (int f = 0; f < 6; f++)
      begin
         make_random_frame();
         send_frame(1'b1);
         idle_cycles(100 + int'($urandom_range(60)));
      end
      wait_output_drain();
      check_value("overflow_stays_low", 16'd0, {15'd0, overflow});
      end_test();

      // Third frame lands in a bank the controller still holds.
      start_test("back_to_back_overflow");
      check_outputs = 1'b0;
      for (int f = 0; f < 4; f++)
      begin
         make_random_frame();
         drive_samples(FFT_N);
      end
      end_input();
      check_value("overflow_set", 16'd1, {15'd0, overflow});
      held = 1'b1;
      repeat (300)
      begin
         @(negedge clk);
         if (!overflow)
         begin
            held = 1'b0;
         end
      end
      check_value("overflow_held", 16'd1, {15'd0, held});
      apply_reset();
      check_value("overflow_cleared", 16'd0, {15'd0, overflow});
      check_outputs = 1'b1;
      end_test();

      // One frame in flight and half of the next, then reset.
      start_test("reset_mid_frame");
      make_random_frame();
      send_frame(1'b0);
      make_random_frame();
      drive_samples(FFT_N / 2);
      end_input();
      idle_cycles(20);
      apply_reset();
      stale = 0;
      repeat (QUIET_CYCLES)
      begin
         @(negedge clk);
         if (out_nd)
         begin
            stale++;
         end
      end
      check_value("no_stale_output", 16'd0, 16'(stale));
      make_random_frame();
      send_frame(1'b1);
      wait_output_drain();
      end_test();

      $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
      if (errors == 0)
      begin
         $display("ALL CHECKS PASSED");
      end
      else
      begin
         $display("CHECKS FAILED");
      end
      $finish;
   end

endmodule

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the FFT testbench with Verilator, runs it and checks the log.
set -u
cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module fft_dit_tb \
   -f src.f -Mdir "$BUILD_DIR" -o fft_dit_sim
if [ $? -ne 0 ]; then
   echo "build failed"
   exit 1
fi

"./$BUILD_DIR/fft_dit_sim" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if grep -q "CHECKS FAILED" "$LOG"; then
   echo "result: fail"
   exit 1
fi
echo "result: pass"
exit 0

// File: src.f
hdl/fft_pkg.sv
hdl/fft_input_buffer.sv
hdl/fft_stage_control.sv
hdl/twiddle_rom.sv
hdl/butterfly.sv
hdl/fft_work_memory.sv
hdl/fft_output_buffer.sv
hdl/fft_dit_top.sv
sim/tb_clock.sv
sim/fft_dit_tb.sv
